// ==== hdl/svreal_defines.svh ====
`ifndef SVREAL_DEFINES_SVH
`define SVREAL_DEFINES_SVH

// width of the signed significand
`define SVREAL_SIG_WIDTH 18

// width of the signed power-of-two exponent
`define SVREAL_EXP_WIDTH 16

// integer port width, used for both conversions
`define SVREAL_INT_WIDTH 16

`endif

// ==== hdl/svreal_pkg.sv ====
`default_nettype none

`include "svreal_defines.svh"

package svreal_pkg;

    // operations of the unit
    typedef enum logic [3:0] {
        OP_ADD      = 4'd0,
        OP_SUB      = 4'd1,
        OP_MUL      = 4'd2,
        OP_MIN      = 4'd3,
        OP_MAX      = 4'd4,
        OP_GT       = 4'd5,
        OP_GE       = 4'd6,
        OP_LT       = 4'd7,
        OP_LE       = 4'd8,
        OP_EQ       = 4'd9,
        OP_NE       = 4'd10,
        OP_TO_INT   = 4'd11,
        OP_FROM_INT = 4'd12
    } svreal_op_e;

    typedef logic signed [`SVREAL_SIG_WIDTH-1:0] svreal_sig_t;

    typedef logic signed [`SVREAL_EXP_WIDTH-1:0] svreal_exp_t;

    typedef logic signed [`SVREAL_INT_WIDTH-1:0] svreal_int_t;

    // value = sig * 2**exp
    typedef struct packed {
        svreal_sig_t sig;
        svreal_exp_t exp;
    } svreal_t;

endpackage

`default_nettype wire

// ==== hdl/svreal_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "svreal_defines.svh"

module svreal_align
    import svreal_pkg::*;
#(
    parameter int IN_WIDTH  = `SVREAL_SIG_WIDTH,
    parameter int OUT_WIDTH = `SVREAL_SIG_WIDTH
) (
    input  wire logic signed [IN_WIDTH-1:0]  sig_i,
    input  wire svreal_exp_t                 exp_i,
    input  wire svreal_exp_t                 exp_o,
    output logic signed [OUT_WIDTH-1:0]      sig_o
);

    // working width covers both sides so nothing is lost before the resize
    localparam int WORK_WIDTH = (IN_WIDTH > OUT_WIDTH) ? IN_WIDTH : OUT_WIDTH;

    // one extra bit so the difference never overflows
    logic signed [`SVREAL_EXP_WIDTH:0] diff;
    logic [`SVREAL_EXP_WIDTH:0]        shamt;
    logic signed [WORK_WIDTH-1:0]      sig_ext;
    logic signed [WORK_WIDTH-1:0]      shifted;

    assign diff    = exp_i - exp_o;
    assign shamt   = diff[`SVREAL_EXP_WIDTH] ? -diff : diff;
    assign sig_ext = sig_i;

    always_comb begin
        if (diff[`SVREAL_EXP_WIDTH]) begin
            // exponent grows, drop low bits toward minus infinity
            shifted = sig_ext >>> shamt;
        end else begin
            // exponent shrinks, top bits wrap off below
            shifted = sig_ext <<< shamt;
        end
    end

    assign sig_o = shifted[OUT_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== hdl/svreal_arith.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "svreal_defines.svh"

module svreal_arith
    import svreal_pkg::*;
(
    input  wire svreal_op_e  op_i,
    input  wire svreal_t     a_i,
    input  wire svreal_t     b_i,
    input  wire svreal_exp_t res_exp_i,
    output svreal_sig_t      sum_o,
    output svreal_sig_t      prod_o
);

    // full product, no bits dropped before alignment
    localparam int PROD_WIDTH = 2 * `SVREAL_SIG_WIDTH;

    svreal_sig_t                   a_al;
    svreal_sig_t                   b_al;
    logic signed [PROD_WIDTH-1:0]  prod;
    svreal_exp_t                   prod_exp;

    // addends brought to the result exponent
    svreal_align #(
        .IN_WIDTH  (`SVREAL_SIG_WIDTH),
        .OUT_WIDTH (`SVREAL_SIG_WIDTH)
    ) align_a (
        .sig_i (a_i.sig),
        .exp_i (a_i.exp),
        .exp_o (res_exp_i),
        .sig_o (a_al)
    );

    svreal_align #(
        .IN_WIDTH  (`SVREAL_SIG_WIDTH),
        .OUT_WIDTH (`SVREAL_SIG_WIDTH)
    ) align_b (
        .sig_i (b_i.sig),
        .exp_i (b_i.exp),
        .exp_o (res_exp_i),
        .sig_o (b_al)
    );

    // wraps on overflow at the significand width
    always_comb begin
        if (op_i == OP_SUB) begin
            sum_o = a_al - b_al;
        end else begin
            sum_o = a_al + b_al;
        end
    end

    assign prod     = a_i.sig * b_i.sig;
    assign prod_exp = a_i.exp + b_i.exp;

    // product narrowed into the result format
    svreal_align #(
        .IN_WIDTH  (PROD_WIDTH),
        .OUT_WIDTH (`SVREAL_SIG_WIDTH)
    ) align_prod (
        .sig_i (prod),
        .exp_i (prod_exp),
        .exp_o (res_exp_i),
        .sig_o (prod_o)
    );

endmodule

`default_nettype wire

// ==== hdl/svreal_compare.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "svreal_defines.svh"

module svreal_compare
    import svreal_pkg::*;
(
    input  wire svreal_op_e  op_i,
    input  wire svreal_t     a_i,
    input  wire svreal_t     b_i,
    input  wire svreal_exp_t res_exp_i,
    output logic             flag_o,
    output svreal_sig_t      minmax_o
);

    svreal_exp_t max_exp;
    svreal_sig_t a_al;
    svreal_sig_t b_al;
    logic        sel_b;
    svreal_t     chosen;

    // common exponent is the larger one
    assign max_exp = (a_i.exp >= b_i.exp) ? a_i.exp : b_i.exp;

    svreal_align #(
        .IN_WIDTH  (`SVREAL_SIG_WIDTH),
        .OUT_WIDTH (`SVREAL_SIG_WIDTH)
    ) align_a (
        .sig_i (a_i.sig),
        .exp_i (a_i.exp),
        .exp_o (max_exp),
        .sig_o (a_al)
    );

    svreal_align #(
        .IN_WIDTH  (`SVREAL_SIG_WIDTH),
        .OUT_WIDTH (`SVREAL_SIG_WIDTH)
    ) align_b (
        .sig_i (b_i.sig),
        .exp_i (b_i.exp),
        .exp_o (max_exp),
        .sig_o (b_al)
    );

    always_comb begin
        case (op_i)
            OP_GT:   flag_o = (a_al > b_al);
            OP_GE:   flag_o = (a_al >= b_al);
            OP_LT:   flag_o = (a_al < b_al);
            OP_LE:   flag_o = (a_al <= b_al);
            OP_EQ:   flag_o = (a_al == b_al);
            OP_NE:   flag_o = (a_al != b_al);
            default: flag_o = 1'b0;
        endcase
    end

    // b wins only on a strict inequality, ties keep a
    assign sel_b  = (op_i == OP_MAX) ? (b_al > a_al) : (b_al < a_al);
    assign chosen = sel_b ? b_i : a_i;

    svreal_align #(
        .IN_WIDTH  (`SVREAL_SIG_WIDTH),
        .OUT_WIDTH (`SVREAL_SIG_WIDTH)
    ) align_chosen (
        .sig_i (chosen.sig),
        .exp_i (chosen.exp),
        .exp_o (res_exp_i),
        .sig_o (minmax_o)
    );

endmodule

`default_nettype wire

// ==== hdl/svreal_int_conv.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "svreal_defines.svh"

module svreal_int_conv
    import svreal_pkg::*;
(
    input  wire svreal_t     a_i,
    input  wire svreal_int_t int_i,
    input  wire svreal_exp_t res_exp_i,
    output svreal_int_t      int_o,
    output svreal_sig_t      from_int_o
);

    // an integer is a value at exponent zero
    localparam svreal_exp_t INT_EXP = '0;

    // to integer, truncated toward minus infinity
    svreal_align #(
        .IN_WIDTH  (`SVREAL_SIG_WIDTH),
        .OUT_WIDTH (`SVREAL_INT_WIDTH)
    ) align_to_int (
        .sig_i (a_i.sig),
        .exp_i (a_i.exp),
        .exp_o (INT_EXP),
        .sig_o (int_o)
    );

    // from integer into the result exponent
    svreal_align #(
        .IN_WIDTH  (`SVREAL_INT_WIDTH),
        .OUT_WIDTH (`SVREAL_SIG_WIDTH)
    ) align_from_int (
        .sig_i (int_i),
        .exp_i (INT_EXP),
        .exp_o (res_exp_i),
        .sig_o (from_int_o)
    );

endmodule

`default_nettype wire

// ==== hdl/svreal_result_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module svreal_result_reg
    import svreal_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        op_valid_i,
    input  wire svreal_op_e  op_i,
    input  wire svreal_exp_t res_exp_i,
    input  wire svreal_sig_t sum_i,
    input  wire svreal_sig_t prod_i,
    input  wire svreal_sig_t minmax_i,
    input  wire svreal_sig_t from_int_i,
    input  wire logic        flag_i,
    input  wire svreal_int_t int_i,
    output svreal_t          result_o,
    output svreal_int_t      int_o,
    output logic             flag_o,
    output logic             valid_o
);

    svreal_sig_t sig_d;
    logic        flag_d;
    svreal_int_t int_d;

    // unused fields stay zero for the opcode
    always_comb begin
        sig_d  = '0;
        flag_d = 1'b0;
        int_d  = '0;
        case (op_i)
            OP_ADD, OP_SUB: sig_d = sum_i;
            OP_MUL:         sig_d = prod_i;
            OP_MIN, OP_MAX: sig_d = minmax_i;
            OP_GT, OP_GE, OP_LT, OP_LE, OP_EQ, OP_NE: begin
                flag_d = flag_i;
            end
            OP_TO_INT:      int_d = int_i;
            OP_FROM_INT:    sig_d = from_int_i;
            default: begin
                sig_d = '0;
            end
        endcase
    end

    // strobe acts as the clock enable
    always_ff @(posedge clk) begin
        if (rst) begin
            result_o <= '0;
            int_o    <= '0;
            flag_o   <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            valid_o <= op_valid_i;
            if (op_valid_i) begin
                result_o.sig <= sig_d;
                result_o.exp <= res_exp_i;
                int_o        <= int_d;
                flag_o       <= flag_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/svreal_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module svreal_alu
    import svreal_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        op_valid_i,
    input  wire svreal_op_e  op_i,
    input  wire svreal_t     a_i,
    input  wire svreal_t     b_i,
    input  wire svreal_int_t int_i,
    input  wire svreal_exp_t res_exp_i,
    output svreal_t          result_o,
    output svreal_int_t      int_o,
    output logic             flag_o,
    output logic             valid_o
);

    svreal_sig_t sum;
    svreal_sig_t prod;
    svreal_sig_t minmax;
    svreal_sig_t from_int;
    logic        cmp_flag;
    svreal_int_t to_int;

    svreal_arith arith0 (
        .op_i      (op_i),
        .a_i       (a_i),
        .b_i       (b_i),
        .res_exp_i (res_exp_i),
        .sum_o     (sum),
        .prod_o    (prod)
    );

    svreal_compare compare0 (
        .op_i      (op_i),
        .a_i       (a_i),
        .b_i       (b_i),
        .res_exp_i (res_exp_i),
        .flag_o    (cmp_flag),
        .minmax_o  (minmax)
    );

    svreal_int_conv int_conv0 (
        .a_i        (a_i),
        .int_i      (int_i),
        .res_exp_i  (res_exp_i),
        .int_o      (to_int),
        .from_int_o (from_int)
    );

    // single register stage, one cycle from strobe to valid
    svreal_result_reg result_reg0 (
        .clk        (clk),
        .rst        (rst),
        .op_valid_i (op_valid_i),
        .op_i       (op_i),
        .res_exp_i  (res_exp_i),
        .sum_i      (sum),
        .prod_i     (prod),
        .minmax_i   (minmax),
        .from_int_i (from_int),
        .flag_i     (cmp_flag),
        .int_i      (to_int),
        .result_o   (result_o),
        .int_o      (int_o),
        .flag_o     (flag_o),
        .valid_o    (valid_o)
    );

endmodule

`default_nettype wire

// ==== sim/svreal_alu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "svreal_defines.svh"

module svreal_alu_tb
    import svreal_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int NUM_RANDOM     = 200;
    localparam int SIG_W          = `SVREAL_SIG_WIDTH;
    localparam int INT_W          = `SVREAL_INT_WIDTH;

    // one operation with its expected response
    typedef struct packed {
        svreal_op_e  op;
        svreal_t     a;
        svreal_t     b;
        svreal_int_t int_in;
        svreal_exp_t res_exp;
        svreal_sig_t exp_sig;
        logic        exp_flag;
        svreal_int_t exp_int;
    } vec_t;

    logic        clk;
    logic        rst;
    logic        op_valid_i;
    svreal_op_e  op_i;
    svreal_t     a_i;
    svreal_t     b_i;
    svreal_int_t int_i;
    svreal_exp_t res_exp_i;
    svreal_t     result_o;
    svreal_int_t int_o;
    logic        flag_o;
    logic        valid_o;

    vec_t        table_q[$];
    logic [31:0] lfsr_state;
    int          errors;

    svreal_alu dut0 (
        .clk        (clk),
        .rst        (rst),
        .op_valid_i (op_valid_i),
        .op_i       (op_i),
        .a_i        (a_i),
        .b_i        (b_i),
        .int_i      (int_i),
        .res_exp_i  (res_exp_i),
        .result_o   (result_o),
        .int_o      (int_o),
        .flag_o     (flag_o),
        .valid_o    (valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // low width bits read back as signed
    function automatic longint wrap_bits(input longint v, input int width);
        longint low;
        low = v & ((64'sd1 <<< width) - 1);
        if (low >= (64'sd1 <<< (width - 1))) begin
            low = low - (64'sd1 <<< width);
        end
        return low;
    endfunction

    function automatic longint align_model(input longint v, input int e_in, input int e_out,
                                           input int width);
        int     d;
        longint r;
        d = e_in - e_out;
        if (d >= 0) begin
            r = (d > 62) ? 64'sd0 : (v <<< d);
        end else if (-d > 62) begin
            r = (v < 0) ? -64'sd1 : 64'sd0;
        end else begin
            r = v >>> (-d);
        end
        return wrap_bits(r, width);
    endfunction

    function automatic vec_t model_op(input vec_t v);
        vec_t   r;
        longint a_sig;
        longint b_sig;
        longint a_cmp;
        longint b_cmp;
        int     a_exp;
        int     b_exp;
        int     re;
        int     me;
        r     = v;
        a_sig = $signed(v.a.sig);
        b_sig = $signed(v.b.sig);
        a_exp = $signed(v.a.exp);
        b_exp = $signed(v.b.exp);
        re    = $signed(v.res_exp);
        me    = (a_exp >= b_exp) ? a_exp : b_exp;
        a_cmp = align_model(a_sig, a_exp, me, SIG_W);
        b_cmp = align_model(b_sig, b_exp, me, SIG_W);
        r.exp_sig  = '0;
        r.exp_flag = 1'b0;
        r.exp_int  = '0;
        case (v.op)
            OP_ADD: r.exp_sig = wrap_bits(align_model(a_sig, a_exp, re, SIG_W)
                                        + align_model(b_sig, b_exp, re, SIG_W), SIG_W);
            OP_SUB: r.exp_sig = wrap_bits(align_model(a_sig, a_exp, re, SIG_W)
                                        - align_model(b_sig, b_exp, re, SIG_W), SIG_W);
            OP_MUL: r.exp_sig = align_model(a_sig * b_sig, a_exp + b_exp, re, SIG_W);
            OP_MIN: r.exp_sig = (b_cmp < a_cmp) ? align_model(b_sig, b_exp, re, SIG_W)
                                                : align_model(a_sig, a_exp, re, SIG_W);
            OP_MAX: r.exp_sig = (b_cmp > a_cmp) ? align_model(b_sig, b_exp, re, SIG_W)
                                                : align_model(a_sig, a_exp, re, SIG_W);
            OP_GT: r.exp_flag = (a_cmp > b_cmp);
            OP_GE: r.exp_flag = (a_cmp >= b_cmp);
            OP_LT: r.exp_flag = (a_cmp < b_cmp);
            OP_LE: r.exp_flag = (a_cmp <= b_cmp);
            OP_EQ: r.exp_flag = (a_cmp == b_cmp);
            OP_NE: r.exp_flag = (a_cmp != b_cmp);
            OP_TO_INT: r.exp_int = align_model(a_sig, a_exp, 0, INT_W);
            OP_FROM_INT: r.exp_sig = align_model($signed(v.int_in), 0, re, SIG_W);
            default: r.exp_sig = '0;
        endcase
        return r;
    endfunction

    task automatic add_row(input svreal_op_e op, input int a_sig, input int a_exp,
                           input int b_sig, input int b_exp, input int int_in,
                           input int res_exp, input int exp_sig, input logic exp_flag,
                           input int exp_int);
        vec_t v;
        v.op       = op;
        v.a.sig    = a_sig;
        v.a.exp    = a_exp;
        v.b.sig    = b_sig;
        v.b.exp    = b_exp;
        v.int_in   = int_in;
        v.res_exp  = res_exp;
        v.exp_sig  = exp_sig;
        v.exp_flag = exp_flag;
        v.exp_int  = exp_int;
        table_q.push_back(v);
    endtask

    task automatic build_table();
        // op, a sig/exp, b sig/exp, int, res exp, expected sig/flag/int
        add_row(OP_ADD, 3, -1, 5, 1, 0, -2, 46, 1'b0, 0);
        add_row(OP_ADD, 7, 0, -3, 0, 0, 1, 1, 1'b0, 0);
        add_row(OP_ADD, 131071, 0, 1, 0, 0, 0, -131072, 1'b0, 0);
        add_row(OP_SUB, 10, 2, -6, -1, 0, 0, 43, 1'b0, 0);
        add_row(OP_SUB, -3, 2, 4, 0, 0, 0, -16, 1'b0, 0);
        add_row(OP_MUL, -5, 2, 3, -1, 0, -1, -60, 1'b0, 0);
        add_row(OP_MUL, 7, 0, -3, 0, 0, 2, -6, 1'b0, 0);
        add_row(OP_MUL, 1000, 0, 1000, 0, 0, 0, -48576, 1'b0, 0);
        // 8 stored two ways
        add_row(OP_GT, 4, 1, 2, 2, 0, 0, 0, 1'b0, 0);
        add_row(OP_GE, 4, 1, 2, 2, 0, 0, 0, 1'b1, 0);
        add_row(OP_LE, 4, 1, 2, 2, 0, 0, 0, 1'b1, 0);
        add_row(OP_EQ, 4, 1, 2, 2, 0, 0, 0, 1'b1, 0);
        add_row(OP_LT, -3, 0, 1, 0, 0, 0, 0, 1'b1, 0);
        add_row(OP_NE, -3, 0, 1, 0, 0, 0, 0, 1'b1, 0);
        add_row(OP_MIN, 6, 0, -2, 1, 0, 0, -4, 1'b0, 0);
        add_row(OP_MAX, 6, 0, -2, 1, 0, 0, 6, 1'b0, 0);
        add_row(OP_MAX, 4, 1, 2, 2, 0, 0, 8, 1'b0, 0);
        add_row(OP_TO_INT, -7, -1, 0, 0, 0, 0, 0, 1'b0, -4);
        add_row(OP_TO_INT, 5, 3, 0, 0, 0, 0, 0, 1'b0, 40);
        add_row(OP_FROM_INT, 0, 0, 0, 0, -9, 1, -5, 1'b0, 0);
        add_row(OP_FROM_INT, 0, 0, 0, 0, 100, -3, 800, 1'b0, 0);
    endtask

    task automatic random_vec(output vec_t v);
        logic [31:0] bits;
        draw_bits(4, bits);
        v.op = svreal_op_e'(bits % 13);
        draw_bits(SIG_W, bits);
        v.a.sig = bits[SIG_W-1:0];
        draw_bits(4, bits);
        v.a.exp = $signed(bits[3:0]);
        draw_bits(SIG_W, bits);
        v.b.sig = bits[SIG_W-1:0];
        draw_bits(4, bits);
        v.b.exp = $signed(bits[3:0]);
        draw_bits(INT_W, bits);
        v.int_in = bits[INT_W-1:0];
        draw_bits(4, bits);
        v.res_exp = $signed(bits[3:0]);
        v = model_op(v);
    endtask

    task automatic check_value(input longint got, input longint want, input string what);
        if (got !== want) begin
            errors++;
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
            $display("Simulation FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_outputs(input vec_t v, input string tag);
        check_value($signed(result_o.sig), $signed(v.exp_sig), {tag, " result sig"});
        check_value($signed(result_o.exp), $signed(v.res_exp), {tag, " result exp"});
        check_value(flag_o, v.exp_flag, {tag, " flag"});
        check_value($signed(int_o), $signed(v.exp_int), {tag, " int"});
    endtask

    task automatic drive_inputs(input vec_t v);
        op_i      = v.op;
        a_i       = v.a;
        b_i       = v.b;
        int_i     = v.int_in;
        res_exp_i = v.res_exp;
    endtask

    task automatic wait_for_valid(input string tag);
        int cycles;
        cycles = 0;
        while (valid_o !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (valid_o !== 1'b1) begin
            $display("ERROR: valid_o never came within %0d cycles for %s", TIMEOUT_CYCLES, tag);
            $display("Simulation FAILED");
            $fatal(1, "timeout waiting for valid_o");
        end
    endtask

    initial begin
        vec_t  cur;
        string tag;
        errors      = 0;
        lfsr_state  = 32'he961;
        rst         = 1'b1;
        op_valid_i  = 1'b0;
        op_i        = OP_ADD;
        a_i         = '0;
        b_i         = '0;
        int_i       = '0;
        res_exp_i   = '0;
        build_table();

        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value(valid_o, 0, "valid after reset");
        check_value(flag_o, 0, "flag after reset");
        check_value(int_o, 0, "int after reset");
        check_value(result_o.sig, 0, "result sig after reset");

        // one strobe per row followed by an idle cycle for the pulse end and the hold
        foreach (table_q[i]) begin
            tag = $sformatf("row %0d", i);
            drive_inputs(table_q[i]);
            op_valid_i = 1'b1;
            @(negedge clk);
            op_valid_i = 1'b0;
            // a new exponent while idle must not reach the outputs
            res_exp_i  = ~table_q[i].res_exp;
            wait_for_valid(tag);
            check_outputs(table_q[i], tag);
            @(negedge clk);
            check_value(valid_o, 0, {tag, " valid after pulse"});
            check_outputs(table_q[i], {tag, " hold"});
        end

        // strobe every cycle with each result due at the next falling edge
        for (int k = 0; k < NUM_RANDOM; k++) begin
            tag = $sformatf("random %0d", k);
            random_vec(cur);
            drive_inputs(cur);
            op_valid_i = 1'b1;
            @(negedge clk);
            check_value(valid_o, 1, {tag, " valid"});
            check_outputs(cur, tag);
        end

        op_valid_i = 1'b0;
        op_i       = OP_TO_INT;
        res_exp_i  = ~res_exp_i;
        repeat (2) begin
            @(negedge clk);
            check_value(valid_o, 0, "valid while idle");
            check_outputs(cur, "idle hold");
        end

        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hdl
hdl/svreal_pkg.sv
hdl/svreal_align.sv
hdl/svreal_arith.sv
hdl/svreal_compare.sv
hdl/svreal_int_conv.sv
hdl/svreal_result_reg.sv
hdl/svreal_alu.sv
sim/svreal_alu_tb.sv
